// File: pinmux_top.f
verilog/pinmux_pkg.sv
verilog/pulse_timebase.sv
verilog/pwm_gen.sv
verilog/gpio_intr.sv
verilog/pad_mux.sv
verilog/pinmux_reg.sv
verilog/pinmux_top.sv
test/pinmux_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the pin mux testbench with Verilator, run it, then search the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --top-module pinmux_tb -f pinmux_top.f \
  -o pinmux_sim > build.log 2>&1 \
  && ./obj_dir/pinmux_sim > sim.log 2>&1 \
  || echo "Build or simulation ended with an error, see build.log and sim.log"

grep -qx "TESTS PASSED" sim.log && echo "Simulation passed" \
  || { echo "Simulation failed, see sim.log"; exit 1; }

// File: test/pinmux_tb.sv
module pinmux_tb import pinmux_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int WAIT_LIMIT  = 50;
  localparam int PULSE_LIMIT = 5000;

  logic       mclk;
  logic       rst_n_i;
  logic       reg_cs_i;
  logic       reg_wr_i;
  reg_addr_t  reg_addr_i;
  reg_data_t  reg_wdata_i;
  reg_be_t    reg_be_i;
  reg_data_t  reg_rdata_o;
  logic       reg_ack_o;
  pad_vec_t   pad_in_i;
  pad_vec_t   pad_out_o;
  pad_vec_t   pad_oen_o;
  logic       uart_txd_i;
  logic       uart_rxd_o;
  logic       irq_o;
  logic       pulse1m_o;

  integer     seed;
  int         err_cnt;
  int         timeout_cnt;

  // Expected register contents, updated when a write is acknowledged
  gpio_word_t sh_dir;
  gpio_word_t sh_out;
  gpio_word_t sh_mask;
  gpio_word_t sh_pos;
  gpio_word_t sh_neg;
  reg_data_t  sh_mf;
  reg_data_t  sh_pulse;
  reg_data_t  sh_pwm [NUM_PWM];

  pinmux_top DUT (
    .mclk        (mclk),
    .rst_n_i     (rst_n_i),
    .reg_cs_i    (reg_cs_i),
    .reg_wr_i    (reg_wr_i),
    .reg_addr_i  (reg_addr_i),
    .reg_wdata_i (reg_wdata_i),
    .reg_be_i    (reg_be_i),
    .reg_rdata_o (reg_rdata_o),
    .reg_ack_o   (reg_ack_o),
    .pad_in_i    (pad_in_i),
    .pad_out_o   (pad_out_o),
    .pad_oen_o   (pad_oen_o),
    .uart_txd_i  (uart_txd_i),
    .uart_rxd_o  (uart_rxd_o),
    .irq_o       (irq_o),
    .pulse1m_o   (pulse1m_o)
  );

  // 50 MHz
  always #10 mclk = ~mclk;

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  // Port bit per pad, A=0..7 up to D=24..31, -1 for pad 17
  function automatic int pad_port_bit(input int pad);
    case (pad)
      0:                      return 22;
      1, 2, 3, 4, 5:          return 23 + pad;
      6, 7:                   return 8 + pad;
      8, 9, 10:               return 21 + pad;
      11, 12, 13, 14, 15, 16: return pad - 3;
      18, 19, 20, 21, 22, 23: return pad - 2;
      default:                return -1;
    endcase
  endfunction

  // Pads of PWM0..PWM5
  function automatic int pwm_pad(input int k);
    case (k)
      0:       return 4;
      1:       return 8;
      2:       return 9;
      3:       return 12;
      4:       return 13;
      default: return 14;
    endcase
  endfunction

  function automatic pad_vec_t pwm_pad_mask(input pwm_vec_t enb);
    pad_vec_t m;
    m = '0;
    for (int k = 0; k < NUM_PWM; k++) begin
      if (enb[k]) m[pwm_pad(k)] = 1'b1;
    end
    return m;
  endfunction

  // Port word seen through the pad map, unmapped bits stay 0
  function automatic gpio_word_t port_from_pads(input pad_vec_t pads);
    gpio_word_t w;
    int         b;
    w = '0;
    for (int p = 0; p < NUM_PAD; p++) begin
      b = pad_port_bit(p);
      if (b >= 0) w[b] = pads[p];
    end
    return w;
  endfunction

  // {pad_out, pad_oen}, UART over PWM over direction
  // PWM pads carry 0 here, their waveform is checked on its own
  function automatic logic [47:0] expect_pads(input gpio_word_t dir, input gpio_word_t out,
                                              input pwm_vec_t enb, input logic uart_on,
                                              input logic txd);
    pad_vec_t po;
    pad_vec_t oe;
    int       b;
    po = '0;
    oe = '1;
    for (int p = 0; p < NUM_PAD; p++) begin
      b = pad_port_bit(p);
      if (b >= 0 && dir[b]) begin
        po[p] = out[b];
        oe[p] = 1'b0;
      end
    end
    for (int k = 0; k < NUM_PWM; k++) begin
      if (enb[k]) begin
        po[pwm_pad(k)] = 1'b0;
        oe[pwm_pad(k)] = 1'b0;
      end
    end
    if (uart_on) begin
      po[1] = 1'b0;
      oe[1] = 1'b1;
      po[2] = txd;
      oe[2] = 1'b0;
    end
    return {po, oe};
  endfunction

  function automatic logic pwm_level(input int tick, input int high, input int low);
    return (tick % (high + low)) < high;
  endfunction

  function automatic reg_data_t merge_bytes(input reg_data_t old_val, input reg_data_t new_val,
                                            input reg_be_t be);
    reg_data_t res;
    res = old_val;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) res[8*b +: 8] = new_val[8*b +: 8];
    end
    return res;
  endfunction

  // Readback of the writable registers, unmapped gives 0
  function automatic reg_data_t shadow_read(input reg_addr_t addr);
    int idx;
    idx = (int'(addr) - int'(ADDR_PWM_BASE)) / 4;
    case (addr)
      ADDR_GPIO_DIR:    return sh_dir;
      ADDR_GPIO_OUT:    return sh_out;
      ADDR_MULTI_FUNC:  return sh_mf;
      ADDR_INTR_MASK:   return sh_mask;
      ADDR_POSEDGE_SEL: return sh_pos;
      ADDR_NEGEDGE_SEL: return sh_neg;
      ADDR_PULSE_1US:   return sh_pulse;
      default: begin
        if (idx >= 0 && idx < NUM_PWM && addr[1:0] == 2'b00) return sh_pwm[idx];
        return '0;
      end
    endcase
  endfunction

  // GPIO_IN and status writes leave the model alone
  task automatic apply_shadow_write(input reg_addr_t addr, input reg_data_t data,
                                    input reg_be_t be);
    reg_data_t val;
    int        idx;
    val = merge_bytes(shadow_read(addr), data, be);
    idx = (int'(addr) - int'(ADDR_PWM_BASE)) / 4;
    case (addr)
      ADDR_GPIO_DIR:    sh_dir   = val;
      ADDR_GPIO_OUT:    sh_out   = val;
      ADDR_MULTI_FUNC:  sh_mf    = val & 32'h0000_013F;
      ADDR_INTR_MASK:   sh_mask  = val;
      ADDR_POSEDGE_SEL: sh_pos   = val;
      ADDR_NEGEDGE_SEL: sh_neg   = val;
      ADDR_PULSE_1US:   sh_pulse = val & 32'h0000_03FF;
      default: begin
        if (idx >= 0 && idx < NUM_PWM && addr[1:0] == 2'b00) sh_pwm[idx] = val;
      end
    endcase
  endtask

  // Configuration registers in test order, PWM words last
  function automatic reg_addr_t cfg_addr(input int idx);
    case (idx)
      0:       return ADDR_GPIO_DIR;
      1:       return ADDR_GPIO_OUT;
      2:       return ADDR_MULTI_FUNC;
      3:       return ADDR_INTR_MASK;
      4:       return ADDR_POSEDGE_SEL;
      5:       return ADDR_NEGEDGE_SEL;
      6:       return ADDR_PULSE_1US;
      default: return ADDR_PWM_BASE + reg_addr_t'(4 * (idx - 7));
    endcase
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Bus and timing helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_equal(input string name, input reg_data_t got, input reg_data_t exp);
    if (got !== exp) begin
      err_cnt++;
      $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // Drive point, 1 ns past the rising edge
  task automatic next_cycle();
    @(posedge mclk);
    #1;
  endtask

  task automatic wait_ack(output bit seen);
    int n;
    seen = 1'b0;
    n = 0;
    while (!seen && n < WAIT_LIMIT) begin
      next_cycle();
      n++;
      seen = reg_ack_o;
    end
    if (!seen) begin
      timeout_cnt++;
      $display("Timeout at %0t: reg_ack_o never came for address %h", $time, reg_addr_i);
    end
  endtask

  task automatic reg_write(input reg_addr_t addr, input reg_data_t data, input reg_be_t be);
    bit seen;
    reg_cs_i    = 1'b1;
    reg_wr_i    = 1'b1;
    reg_addr_i  = addr;
    reg_wdata_i = data;
    reg_be_i    = be;
    wait_ack(seen);
    if (seen) apply_shadow_write(addr, data, be);
    reg_cs_i = 1'b0;
    reg_wr_i = 1'b0;
  endtask

  task automatic reg_read(input reg_addr_t addr, output reg_data_t data);
    bit seen;
    reg_cs_i   = 1'b1;
    reg_wr_i   = 1'b0;
    reg_addr_i = addr;
    wait_ack(seen);
    data = seen ? reg_rdata_o : '0;
    reg_cs_i = 1'b0;
  endtask

  // Cycles until the next pulse1m_o
  task automatic wait_ms_pulse(output int cycles);
    bit seen;
    seen = 1'b0;
    cycles = 0;
    while (!seen && cycles < PULSE_LIMIT) begin
      next_cycle();
      cycles++;
      seen = pulse1m_o;
    end
    if (!seen) begin
      timeout_cnt++;
      $display("Timeout at %0t: pulse1m_o did not pulse within %0d cycles", $time, PULSE_LIMIT);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Pad comparison, mid cycle when everything has settled
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge mclk) begin : pad_compare
    logic [47:0] exp_pads;
    pad_vec_t    pwm_mask;
    if (rst_n_i) begin
      exp_pads = expect_pads(sh_dir, sh_out, sh_mf[5:0], sh_mf[8], uart_txd_i);
      pwm_mask = pwm_pad_mask(sh_mf[5:0]);
      check_equal("pad_oen_o", reg_data_t'(pad_oen_o), reg_data_t'(exp_pads[23:0]));
      check_equal("pad_out_o", reg_data_t'(pad_out_o & ~pwm_mask),
                  reg_data_t'(exp_pads[47:24] & ~pwm_mask));
      check_equal("uart_rxd_o", reg_data_t'(uart_rxd_o),
                  reg_data_t'(sh_mf[8] & pad_in_i[PAD_UART_RXD]));
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    reg_data_t   rd;
    reg_data_t   wd;
    reg_addr_t   addr;
    logic [47:0] pads;
    int          n;
    int          gap;

    mclk        = 1'b0;
    rst_n_i     = 1'b0;
    reg_cs_i    = 1'b0;
    reg_wr_i    = 1'b0;
    reg_addr_i  = '0;
    reg_wdata_i = '0;
    reg_be_i    = '0;
    pad_in_i    = '0;
    uart_txd_i  = 1'b0;
    seed        = 32'h85da;
    err_cnt     = 0;
    timeout_cnt = 0;
    sh_dir      = '0;
    sh_out      = '0;
    sh_mask     = '0;
    sh_pos      = '0;
    sh_neg      = '0;
    sh_mf       = '0;
    sh_pulse    = 32'd49;
    for (int k = 0; k < NUM_PWM; k++) sh_pwm[k] = '0;

    repeat (2) @(posedge mclk);
    #1;
    rst_n_i = 1'b1;

    // Reset values
    check_equal("reg_ack_o", reg_data_t'(reg_ack_o), 32'd0);
    check_equal("irq_o", reg_data_t'(irq_o), 32'd0);
    check_equal("pulse1m_o", reg_data_t'(pulse1m_o), 32'd0);
    reg_read(ADDR_PULSE_1US, rd);
    check_equal("reg_rdata_o", rd, shadow_read(ADDR_PULSE_1US));
    reg_read(8'h40, rd);
    check_equal("reg_rdata_o", rd, 32'd0);

    // Random writes with random byte enables, read back each one
    for (n = 0; n < 52; n++) begin
      addr = cfg_addr(n % 13);
      wd = $random(seed);
      reg_write(addr, wd, reg_be_t'($random(seed)));
      reg_read(addr, rd);
      check_equal("reg_rdata_o", rd, shadow_read(addr));
    end

    // GPIO_IN ignores writes
    pad_in_i = pad_vec_t'($random(seed));
    next_cycle();
    next_cycle();
    reg_write(ADDR_GPIO_IN, $random(seed), 4'hF);
    reg_read(ADDR_GPIO_IN, rd);
    check_equal("reg_rdata_o", rd, port_from_pads(pad_in_i));

    // Quiet state, no selects, no overlay
    reg_write(ADDR_MULTI_FUNC, 32'd0, 4'hF);
    reg_write(ADDR_POSEDGE_SEL, 32'd0, 4'hF);
    reg_write(ADDR_NEGEDGE_SEL, 32'd0, 4'hF);
    reg_write(ADDR_INTR_MASK, 32'd0, 4'hF);

    // GPIO output through the pad map
    for (n = 0; n < 20; n++) begin
      reg_write(ADDR_GPIO_DIR, $random(seed), 4'hF);
      reg_write(ADDR_GPIO_OUT, $random(seed), 4'hF);
      next_cycle();
      pads = expect_pads(sh_dir, sh_out, sh_mf[5:0], sh_mf[8], uart_txd_i);
      check_equal("pad_oen_o", reg_data_t'(pad_oen_o), reg_data_t'(pads[23:0]));
      check_equal("pad_out_o", reg_data_t'(pad_out_o), reg_data_t'(pads[47:24]));
    end

    // GPIO input, two cycles to reach the sample register
    for (n = 0; n < 20; n++) begin
      pad_in_i = pad_vec_t'($random(seed));
      next_cycle();
      next_cycle();
      reg_read(ADDR_GPIO_IN, rd);
      check_equal("reg_rdata_o", rd, port_from_pads(pad_in_i));
    end

    // Interrupts, B0 on pad 11 starts high, D0 on pad 1 starts low
    pad_in_i = 24'h00_0800;
    repeat (3) next_cycle();
    reg_write(ADDR_POSEDGE_SEL, 32'h0100_0000, 4'hF);
    reg_write(ADDR_NEGEDGE_SEL, 32'h0000_0100, 4'hF);
    reg_write(ADDR_INTR_MASK, 32'h0100_0100, 4'hF);
    reg_write(ADDR_INTR_STAT, 32'hFFFF_FFFF, 4'hF);
    check_equal("irq_o", reg_data_t'(irq_o), 32'd0);
    // Rise on D0, fall on B0
    pad_in_i = 24'h00_0002;
    n = 0;
    while (!irq_o && n < WAIT_LIMIT) begin
      next_cycle();
      n++;
    end
    if (!irq_o) begin
      timeout_cnt++;
      $display("Timeout at %0t: irq_o did not rise after the pad edges", $time);
    end
    // Sample, event, status
    check_equal("irq latency", reg_data_t'(n), 32'd3);
    reg_read(ADDR_INTR_STAT, rd);
    check_equal("intr_stat", rd, 32'h0100_0100);
    reg_write(ADDR_INTR_STAT, 32'h0100_0100, 4'hF);
    check_equal("irq_o", reg_data_t'(irq_o), 32'd0);
    reg_read(ADDR_INTR_STAT, rd);
    check_equal("intr_stat", rd, 32'd0);
    reg_write(ADDR_INTR_MASK, 32'd0, 4'hF);
    reg_write(ADDR_POSEDGE_SEL, 32'd0, 4'hF);
    reg_write(ADDR_NEGEDGE_SEL, 32'd0, 4'hF);

    // UART overlay with every port bit set to output
    reg_write(ADDR_GPIO_DIR, 32'hFFFF_FFFF, 4'hF);
    reg_write(ADDR_GPIO_OUT, $random(seed), 4'hF);
    reg_write(ADDR_MULTI_FUNC, 32'h0000_0100, 4'hF);
    for (n = 0; n < 16; n++) begin
      wd = $random(seed);
      uart_txd_i = wd[0];
      pad_in_i = pad_vec_t'($random(seed));
      next_cycle();
      check_equal("pad_out_o[2]", reg_data_t'(pad_out_o[PAD_UART_TXD]),
                  reg_data_t'(uart_txd_i));
      check_equal("pad_oen_o[1]", reg_data_t'(pad_oen_o[PAD_UART_RXD]), 32'd1);
      check_equal("uart_rxd_o", reg_data_t'(uart_rxd_o),
                  reg_data_t'(pad_in_i[PAD_UART_RXD]));
    end

    // All PWMs on, their pads drive regardless of direction
    reg_write(ADDR_GPIO_DIR, 32'd0, 4'hF);
    reg_write(ADDR_MULTI_FUNC, 32'h0000_003F, 4'hF);
    next_cycle();
    pads = expect_pads(sh_dir, sh_out, sh_mf[5:0], sh_mf[8], uart_txd_i);
    check_equal("pad_oen_o", reg_data_t'(pad_oen_o), reg_data_t'(pads[23:0]));
    reg_write(ADDR_MULTI_FUNC, 32'd0, 4'hF);

    // 1 us every 2 clocks, so 2000 clocks per ms
    reg_write(ADDR_PULSE_1US, 32'd1, 4'hF);
    wait_ms_pulse(gap);
    wait_ms_pulse(gap);
    check_equal("pulse1m_o interval", reg_data_t'(gap), 32'd2000);

    // PWM0 on pad 4, 2 ms high then 3 ms low
    reg_write(ADDR_PWM_BASE, 32'h0003_0002, 4'hF);
    wait_ms_pulse(gap);
    reg_write(ADDR_MULTI_FUNC, 32'h0000_0001, 4'hF);
    for (n = 0; n < 10; n++) begin
      wait_ms_pulse(gap);
      // Waveform moves on the edge after the pulse
      next_cycle();
      check_equal("pad_out_o[4]", reg_data_t'(pad_out_o[4]),
                  reg_data_t'(pwm_level(n, 2, 3)));
    end
    reg_write(ADDR_MULTI_FUNC, 32'd0, 4'hF);
    next_cycle();

    $display("Errors: %0d mismatches, %0d timeouts", err_cnt, timeout_cnt);
    if (err_cnt == 0 && timeout_cnt == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: verilog/gpio_intr.sv
module gpio_intr import pinmux_pkg::*; (
  input  logic       mclk,
  input  logic       rst_n_i,
  input  gpio_word_t gpio_sample_i,
  input  gpio_word_t posedge_sel_i,
  input  gpio_word_t negedge_sel_i,
  output gpio_word_t gpio_event_o
);

  gpio_word_t gpio_prev;
  gpio_word_t rise;
  gpio_word_t fall;

  // Edges between this sample and the last one
  assign rise = gpio_sample_i & ~gpio_prev;
  assign fall = ~gpio_sample_i & gpio_prev;

  always_ff @(posedge mclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      gpio_prev    <= '0;
      gpio_event_o <= '0;
    end else begin
      gpio_prev    <= gpio_sample_i;
      // One cycle wide per edge
      gpio_event_o <= (rise & posedge_sel_i) | (fall & negedge_sel_i);
    end
  end

endmodule

// File: verilog/pad_mux.sv
module pad_mux import pinmux_pkg::*; (
  input  gpio_word_t gpio_dir_i,
  input  gpio_word_t gpio_out_i,
  input  pwm_vec_t   pwm_enb_i,
  input  logic       uart_enb_i,
  input  pwm_vec_t   pwm_wfm_i,
  input  logic       uart_txd_i,
  input  pad_vec_t   pad_in_i,
  output pad_vec_t   pad_out_o,
  output pad_vec_t   pad_oen_o,
  output gpio_word_t gpio_in_o,
  output logic       uart_rxd_o
);

  ////////////////////////////////////////////////////////////////////////////
  // Pad map, ATmega328 pinout
  ////////////////////////////////////////////////////////////////////////////

  // Port bit per pad, A=0..7 B=8..15 C=16..23 D=24..31
  localparam logic [4:0] PAD_PORT_BIT [NUM_PAD] = '{
    5'd22,                                 // PC6
    5'd24, 5'd25, 5'd26, 5'd27, 5'd28,     // PD0..PD4
    5'd14, 5'd15,                          // PB6, PB7
    5'd29, 5'd30, 5'd31,                   // PD5..PD7
    5'd8,  5'd9,  5'd10, 5'd11, 5'd12, 5'd13, // PB0..PB5
    5'd0,                                  // no port, see PAD_USED
    5'd16, 5'd17, 5'd18, 5'd19, 5'd20, 5'd21  // PC0..PC5
  };

  // Pad 17 has no port bit
  localparam pad_vec_t PAD_USED = 24'hFD_FFFF;

  // OC2B, OC0B, OC0A, OC1A, OC1B, OC2A
  localparam int PWM_PAD [NUM_PWM] = '{4, 8, 9, 12, 13, 14};

  ////////////////////////////////////////////////////////////////////////////
  // Output and enable, lowest priority first
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    // All pads float as inputs unless something claims them
    pad_out_o = '0;
    pad_oen_o = '1;
    gpio_in_o = '0;

    // Plain GPIO, port direction bit decides
    for (int p = 0; p < NUM_PAD; p++) begin
      if (PAD_USED[p]) begin
        // Input path ignores every enable
        gpio_in_o[PAD_PORT_BIT[p]] = pad_in_i[p];
        if (gpio_dir_i[PAD_PORT_BIT[p]]) begin
          pad_out_o[p] = gpio_out_i[PAD_PORT_BIT[p]];
          pad_oen_o[p] = 1'b0;
        end
      end
    end

    // PWM overrides direction
    for (int k = 0; k < NUM_PWM; k++) begin
      if (pwm_enb_i[k]) begin
        pad_out_o[PWM_PAD[k]] = pwm_wfm_i[k];
        pad_oen_o[PWM_PAD[k]] = 1'b0;
      end
    end

    // UART wins over everything
    if (uart_enb_i) begin
      pad_out_o[PAD_UART_RXD] = 1'b0;
      pad_oen_o[PAD_UART_RXD] = 1'b1;
      pad_out_o[PAD_UART_TXD] = uart_txd_i;
      pad_oen_o[PAD_UART_TXD] = 1'b0;
    end

    // Undriven pads must not carry stale data
    pad_idle_low: assert ((pad_out_o & pad_oen_o) == '0)
      else $error("pad_out_o set on an input pad");
  end

  // Receive line held low while the UART is off
  assign uart_rxd_o = uart_enb_i & pad_in_i[PAD_UART_RXD];

endmodule

// File: verilog/pinmux_pkg.sv
package pinmux_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////////////////////////////////////////

  // 24 digital pads left after the flash, USB and serial pads went away
  localparam int NUM_PAD   = 24;
  localparam int NUM_PWM   = 6;
  // 1 us ticks in one ms tick
  localparam int US_PER_MS = 1000;

  // Register bus
  typedef logic [31:0] reg_data_t;
  typedef logic [7:0]  reg_addr_t;
  typedef logic [3:0]  reg_be_t;

  // Ports A..D packed, A in the low byte
  typedef logic [31:0]        gpio_word_t;
  typedef logic [NUM_PAD-1:0] pad_vec_t;

  // PWM phase length in ms ticks
  typedef logic [15:0]        pwm_cnt_t;
  typedef logic [NUM_PWM-1:0] pwm_vec_t;

  // Clocks per 1 us tick, minus one
  typedef logic [9:0] pulse_cfg_t;

  // 50 MHz mclk by default
  localparam pulse_cfg_t PULSE_CFG_RST = 10'd49;

  ////////////////////////////////////////////////////////////////////////////
  // Register map
  ////////////////////////////////////////////////////////////////////////////

  localparam reg_addr_t ADDR_GPIO_DIR    = 8'h00;
  localparam reg_addr_t ADDR_GPIO_OUT    = 8'h04;
  localparam reg_addr_t ADDR_GPIO_IN     = 8'h08;
  localparam reg_addr_t ADDR_MULTI_FUNC  = 8'h0C;
  localparam reg_addr_t ADDR_INTR_STAT   = 8'h10;
  localparam reg_addr_t ADDR_INTR_MASK   = 8'h14;
  localparam reg_addr_t ADDR_POSEDGE_SEL = 8'h18;
  localparam reg_addr_t ADDR_NEGEDGE_SEL = 8'h1C;
  localparam reg_addr_t ADDR_PULSE_1US   = 8'h20;
  // One word per PWM channel from here, 4 bytes apart
  localparam reg_addr_t ADDR_PWM_BASE    = 8'h24;

  // Multi function word, PWM enables sit in bits 5:0
  localparam int MF_UART_BIT = 8;

  // Pads owned by the UART when enabled
  localparam int PAD_UART_RXD = 1;
  localparam int PAD_UART_TXD = 2;

endpackage

// File: verilog/pinmux_reg.sv
module pinmux_reg import pinmux_pkg::*; (
  input  logic       mclk,
  input  logic       rst_n_i,

  // Register bus
  input  logic       reg_cs_i,
  input  logic       reg_wr_i,
  input  reg_addr_t  reg_addr_i,
  input  reg_data_t  reg_wdata_i,
  input  reg_be_t    reg_be_i,
  output reg_data_t  reg_rdata_o,
  output logic       reg_ack_o,

  // Port inputs from the pads and edge events
  input  gpio_word_t gpio_in_i,
  input  gpio_word_t gpio_event_i,

  // Configuration out
  output gpio_word_t gpio_dir_o,
  output gpio_word_t gpio_out_o,
  output gpio_word_t gpio_sample_o,
  output pwm_vec_t   pwm_enb_o,
  output logic       uart_enb_o,
  output gpio_word_t posedge_sel_o,
  output gpio_word_t negedge_sel_o,
  output pulse_cfg_t pulse_cfg_o,
  output pwm_cnt_t   pwm_high_o [NUM_PWM],
  output pwm_cnt_t   pwm_low_o  [NUM_PWM],
  output logic       irq_o
);

  gpio_word_t intr_stat;
  gpio_word_t intr_mask;
  gpio_word_t stat_clr;
  reg_data_t  be_mask;
  reg_data_t  rd_mux;
  reg_data_t  wr_merge;
  logic       wr_en;
  logic       rd_en;

  // Access starts on the first cycle of cs, ack closes it
  assign wr_en = reg_cs_i & reg_wr_i & ~reg_ack_o;
  assign rd_en = reg_cs_i & ~reg_wr_i & ~reg_ack_o;

  // One mask byte per enable bit
  assign be_mask = {{8{reg_be_i[3]}}, {8{reg_be_i[2]}}, {8{reg_be_i[1]}}, {8{reg_be_i[0]}}};

  ////////////////////////////////////////////////////////////////////////////
  // Read mux
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    rd_mux = '0;
    case (reg_addr_i)
      ADDR_GPIO_DIR:    rd_mux = gpio_dir_o;
      ADDR_GPIO_OUT:    rd_mux = gpio_out_o;
      ADDR_GPIO_IN:     rd_mux = gpio_sample_o;
      ADDR_MULTI_FUNC:  rd_mux = {23'd0, uart_enb_o, 2'd0, pwm_enb_o};
      ADDR_INTR_STAT:   rd_mux = intr_stat;
      ADDR_INTR_MASK:   rd_mux = intr_mask;
      ADDR_POSEDGE_SEL: rd_mux = posedge_sel_o;
      ADDR_NEGEDGE_SEL: rd_mux = negedge_sel_o;
      ADDR_PULSE_1US:   rd_mux = reg_data_t'(pulse_cfg_o);
      default: begin
        // PWM words, anything else reads 0
        for (int k = 0; k < NUM_PWM; k++) begin
          if (reg_addr_i == ADDR_PWM_BASE + reg_addr_t'(4 * k)) begin
            rd_mux = {pwm_low_o[k], pwm_high_o[k]};
          end
        end
      end
    endcase
  end

  // Current register value with the enabled bytes replaced
  assign wr_merge = (rd_mux & ~be_mask) | (reg_wdata_i & be_mask);

  ////////////////////////////////////////////////////////////////////////////
  // Configuration registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge mclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      gpio_dir_o    <= '0;
      gpio_out_o    <= '0;
      pwm_enb_o     <= '0;
      uart_enb_o    <= 1'b0;
      intr_mask     <= '0;
      posedge_sel_o <= '0;
      negedge_sel_o <= '0;
      pulse_cfg_o   <= PULSE_CFG_RST;
      for (int k = 0; k < NUM_PWM; k++) begin
        pwm_high_o[k] <= '0;
        pwm_low_o[k]  <= '0;
      end
    end else if (wr_en) begin
      case (reg_addr_i)
        ADDR_GPIO_DIR:    gpio_dir_o <= wr_merge;
        ADDR_GPIO_OUT:    gpio_out_o <= wr_merge;
        ADDR_MULTI_FUNC: begin
          pwm_enb_o  <= wr_merge[NUM_PWM-1:0];
          uart_enb_o <= wr_merge[MF_UART_BIT];
        end
        ADDR_INTR_MASK:   intr_mask     <= wr_merge;
        ADDR_POSEDGE_SEL: posedge_sel_o <= wr_merge;
        ADDR_NEGEDGE_SEL: negedge_sel_o <= wr_merge;
        ADDR_PULSE_1US:   pulse_cfg_o   <= wr_merge[9:0];
        default: begin
          // GPIO_IN and status are not written here
          for (int k = 0; k < NUM_PWM; k++) begin
            if (reg_addr_i == ADDR_PWM_BASE + reg_addr_t'(4 * k)) begin
              {pwm_low_o[k], pwm_high_o[k]} <= wr_merge;
            end
          end
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Input sample, interrupt status, bus handshake
  ////////////////////////////////////////////////////////////////////////////

  // Write 1 to clear, only the enabled bytes
  assign stat_clr = (wr_en && reg_addr_i == ADDR_INTR_STAT) ? (reg_wdata_i & be_mask) : '0;

  always_ff @(posedge mclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      gpio_sample_o <= '0;
      intr_stat     <= '0;
      reg_ack_o     <= 1'b0;
      reg_rdata_o   <= '0;
    end else begin
      gpio_sample_o <= gpio_in_i;
      // New event beats a clear on the same edge
      intr_stat     <= (intr_stat & ~stat_clr) | gpio_event_i;
      reg_ack_o     <= reg_cs_i & ~reg_ack_o;
      // Data only during the ack cycle
      reg_rdata_o   <= rd_en ? rd_mux : '0;
    end
  end

  // Level interrupt, any unmasked status bit
  assign irq_o = |(intr_stat & intr_mask);

  // Read data shows only in the ack cycle, an idle bus reads 0
  rdata_only_with_ack: assert property (@(posedge mclk) disable iff (!rst_n_i)
    !reg_ack_o |-> reg_rdata_o == '0);

endmodule

// File: verilog/pinmux_top.sv
module pinmux_top import pinmux_pkg::*; (
  input  logic      mclk,
  input  logic      rst_n_i,

  // Register bus
  input  logic      reg_cs_i,
  input  logic      reg_wr_i,
  input  reg_addr_t reg_addr_i,
  input  reg_data_t reg_wdata_i,
  input  reg_be_t   reg_be_i,
  output reg_data_t reg_rdata_o,
  output logic      reg_ack_o,

  // Pads
  input  pad_vec_t  pad_in_i,
  output pad_vec_t  pad_out_o,
  output pad_vec_t  pad_oen_o,

  // UART side
  input  logic      uart_txd_i,
  output logic      uart_rxd_o,

  output logic      irq_o,
  output logic      pulse1m_o
);

  gpio_word_t gpio_dir;
  gpio_word_t gpio_out;
  gpio_word_t gpio_in;
  gpio_word_t gpio_sample;
  gpio_word_t gpio_event;
  gpio_word_t posedge_sel;
  gpio_word_t negedge_sel;
  pwm_vec_t   pwm_enb;
  pwm_vec_t   pwm_wfm;
  logic       uart_enb;
  pulse_cfg_t pulse_cfg;
  pwm_cnt_t   pwm_high [NUM_PWM];
  pwm_cnt_t   pwm_low  [NUM_PWM];

  ////////////////////////////////////////////////////////////////////////////
  // Register block
  ////////////////////////////////////////////////////////////////////////////

  pinmux_reg u_pinmux_reg (
    .mclk          (mclk),
    .rst_n_i       (rst_n_i),
    .reg_cs_i      (reg_cs_i),
    .reg_wr_i      (reg_wr_i),
    .reg_addr_i    (reg_addr_i),
    .reg_wdata_i   (reg_wdata_i),
    .reg_be_i      (reg_be_i),
    .reg_rdata_o   (reg_rdata_o),
    .reg_ack_o     (reg_ack_o),
    .gpio_in_i     (gpio_in),
    .gpio_event_i  (gpio_event),
    .gpio_dir_o    (gpio_dir),
    .gpio_out_o    (gpio_out),
    .gpio_sample_o (gpio_sample),
    .pwm_enb_o     (pwm_enb),
    .uart_enb_o    (uart_enb),
    .posedge_sel_o (posedge_sel),
    .negedge_sel_o (negedge_sel),
    .pulse_cfg_o   (pulse_cfg),
    .pwm_high_o    (pwm_high),
    .pwm_low_o     (pwm_low),
    .irq_o         (irq_o)
  );

  // Edge events one cycle after the sample changes
  gpio_intr u_gpio_intr (
    .mclk          (mclk),
    .rst_n_i       (rst_n_i),
    .gpio_sample_i (gpio_sample),
    .posedge_sel_i (posedge_sel),
    .negedge_sel_i (negedge_sel),
    .gpio_event_o  (gpio_event)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Timebase and PWM channels
  ////////////////////////////////////////////////////////////////////////////

  pulse_timebase u_pulse_timebase (
    .mclk        (mclk),
    .rst_n_i     (rst_n_i),
    .pulse_cfg_i (pulse_cfg),
    .pulse1m_o   (pulse1m_o)
  );

  for (genvar k = 0; k < NUM_PWM; k++) begin : g_pwm
    pwm_gen u_pwm_gen (
      .mclk       (mclk),
      .rst_n_i    (rst_n_i),
      .pulse1m_i  (pulse1m_o),
      .pwm_enb_i  (pwm_enb[k]),
      .pwm_high_i (pwm_high[k]),
      .pwm_low_i  (pwm_low[k]),
      .waveform_o (pwm_wfm[k])
    );
  end

  // Pad side, purely combinational
  pad_mux u_pad_mux (
    .gpio_dir_i (gpio_dir),
    .gpio_out_i (gpio_out),
    .pwm_enb_i  (pwm_enb),
    .uart_enb_i (uart_enb),
    .pwm_wfm_i  (pwm_wfm),
    .uart_txd_i (uart_txd_i),
    .pad_in_i   (pad_in_i),
    .pad_out_o  (pad_out_o),
    .pad_oen_o  (pad_oen_o),
    .gpio_in_o  (gpio_in),
    .uart_rxd_o (uart_rxd_o)
  );

endmodule

// File: verilog/pulse_timebase.sv
module pulse_timebase import pinmux_pkg::*; (
  input  logic       mclk,
  input  logic       rst_n_i,
  input  pulse_cfg_t pulse_cfg_i,
  output logic       pulse1m_o
);

  pulse_cfg_t                     us_cnt;
  logic [$clog2(US_PER_MS)-1:0]   ms_cnt;
  logic                           tick_1us;
  logic                           ms_last;

  // Divider wraps at the configured value
  // Larger count after a config change wraps too
  assign tick_1us = (us_cnt >= pulse_cfg_i);
  assign ms_last  = (ms_cnt == ($clog2(US_PER_MS))'(US_PER_MS - 1));

  // 1 us divider
  always_ff @(posedge mclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      us_cnt <= '0;
    end else if (tick_1us) begin
      us_cnt <= '0;
    end else begin
      us_cnt <= us_cnt + 1'b1;
    end
  end

  // Count 1 us ticks, pulse on every thousandth
  always_ff @(posedge mclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ms_cnt    <= '0;
      pulse1m_o <= 1'b0;
    end else begin
      pulse1m_o <= tick_1us & ms_last;
      if (tick_1us) begin
        ms_cnt <= ms_last ? '0 : ms_cnt + 1'b1;
      end
    end
  end

  // Every PWM counter relies on one count per ms
  ms_pulse_single: assert property (@(posedge mclk) disable iff (!rst_n_i)
    pulse1m_o |=> !pulse1m_o);

endmodule

// File: verilog/pwm_gen.sv
module pwm_gen import pinmux_pkg::*; (
  input  logic     mclk,
  input  logic     rst_n_i,
  input  logic     pulse1m_i,
  input  logic     pwm_enb_i,
  input  pwm_cnt_t pwm_high_i,
  input  pwm_cnt_t pwm_low_i,
  output logic     waveform_o
);

  logic     phase;
  pwm_cnt_t tick_cnt;
  pwm_cnt_t next_len;

  // Length of the phase about to start, zero treated as one tick
  assign next_len = phase ? pwm_low_i : pwm_high_i;

  // Disabled state looks like the end of a low phase
  // So the first tick after enable starts the high phase
  always_ff @(posedge mclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      phase    <= 1'b0;
      tick_cnt <= '0;
    end else if (!pwm_enb_i) begin
      phase    <= 1'b0;
      tick_cnt <= '0;
    end else if (pulse1m_i) begin
      if (tick_cnt == '0) begin
        phase    <= ~phase;
        // Reload counts down to 0 across the new phase
        tick_cnt <= (next_len == '0) ? '0 : next_len - 1'b1;
      end else begin
        tick_cnt <= tick_cnt - 1'b1;
      end
    end
  end

  // Phase register lags enable by a cycle
  assign waveform_o = phase & pwm_enb_i;

  // High phase only opens on a ms tick, never on enable alone
  wfm_rise_on_tick: assert property (@(posedge mclk) disable iff (!rst_n_i)
    $rose(waveform_o) |-> $past(pulse1m_i));

endmodule
